// File: include/bitser_consts.svh
`ifndef BITSER_CONSTS_SVH
`define BITSER_CONSTS_SVH

// Data and address width
`define BITSER_XLEN 32
// Bit counter runs 0 to 31
`define BITSER_CNT_W 5
`define BITSER_NREGS 32
`define BITSER_RESET_PC 32'h0

`endif

// File: src/bitser_isa_pkg.sv
package bitser_isa_pkg;

   typedef enum logic [6:0] {
      OP     = 7'b0110011,
      OP_IMM = 7'b0010011,
      LUI    = 7'b0110111,
      STORE  = 7'b0100011
   } opcode_e;

   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;
   localparam logic [6:0] F7_SUB     = 7'b0100000;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      opcode_e    opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      opcode_e     opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      opcode_e    opcode;
   } s_fmt_t;

   typedef struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      opcode_e     opcode;
   } u_fmt_t;

   // One fetched word, read through whichever format applies
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      s_fmt_t s;
      u_fmt_t u;
   } insn_u;

endpackage

// File: src/bitser_ctrl_pkg.sv
package bitser_ctrl_pkg;

   // Instruction phases
   typedef enum logic [1:0] {
      FETCH,
      EXEC,
      STORE_BUS
   } phase_e;

   // Serial ALU operations
   typedef enum logic [2:0] {
      ADD,
      SUB,
      AND,
      OR,
      XOR,
      PASS_B
   } alu_op_e;

endpackage

// File: src/bitser_rf_if.sv
`default_nettype none
`include "bitser_consts.svh"

interface bitser_rf_if;

   localparam int ADDR_W = $clog2(`BITSER_NREGS);

   logic [`BITSER_CNT_W-1:0] cnt;
   logic [ADDR_W-1:0]        rs1_addr;
   logic [ADDR_W-1:0]        rs2_addr;
   logic [ADDR_W-1:0]        rd_addr;
   logic                     wen;
   logic                     wdata;
   logic                     rs1_bit;
   logic                     rs2_bit;

   modport rf (
      input  cnt, rs1_addr, rs2_addr, rd_addr, wen, wdata,
      output rs1_bit, rs2_bit
   );

   modport core (
      output cnt, rs1_addr, rs2_addr, rd_addr, wen, wdata,
      input  rs1_bit, rs2_bit
   );

endinterface
`default_nettype wire

// File: src/bitser_ctrl.sv
`default_nettype none
`include "bitser_consts.svh"

module bitser_ctrl (
   input  logic                    clk,
   input  logic                    i_reset,
   input  logic                    i_ibus_ack,
   input  logic                    i_dbus_ack,
   input  logic                    i_is_store,
   output logic                    o_ibus_cyc,
   output logic [`BITSER_XLEN-1:0] o_ibus_adr,
   output logic                    o_dbus_cyc,
   output logic                    o_capture,
   output logic                    o_exec_en,
   output logic                    o_cnt_last,
   bitser_rf_if.core               rf
);

   // Bit 2 of the PC increment
   localparam logic [`BITSER_CNT_W-1:0] PC_INC_BIT = 2;

   bitser_ctrl_pkg::phase_e  phase;
   logic [`BITSER_CNT_W-1:0] cnt;
   logic [`BITSER_XLEN-1:0]  pc;
   logic                     pc_carry;
   logic                     pc_add;
   logic                     pc_sum;
   logic                     pc_cout;

   assign o_capture  = o_ibus_cyc & i_ibus_ack;
   assign o_exec_en  = (phase == bitser_ctrl_pkg::EXEC);
   assign o_cnt_last = o_exec_en & (cnt == '1);
   assign o_ibus_adr = pc;
   assign rf.cnt     = cnt;

   // Serial PC + 4, LSB first
   assign pc_add  = (cnt == PC_INC_BIT);
   assign pc_sum  = pc[0] ^ pc_add ^ pc_carry;
   assign pc_cout = (pc[0] & pc_add) | (pc_carry & (pc[0] ^ pc_add));

   always_ff @(posedge clk) begin
      if (i_reset) begin
         phase      <= bitser_ctrl_pkg::FETCH;
         cnt        <= '0;
         pc         <= `BITSER_RESET_PC;
         pc_carry   <= 1'b0;
         o_ibus_cyc <= 1'b0;
         o_dbus_cyc <= 1'b0;
      end else begin
         case (phase)
            bitser_ctrl_pkg::FETCH: begin
               if (o_capture) begin
                  o_ibus_cyc <= 1'b0;
                  phase      <= bitser_ctrl_pkg::EXEC;
               end else begin
                  // First request after reset, then held until ack
                  o_ibus_cyc <= 1'b1;
               end
            end
            bitser_ctrl_pkg::EXEC: begin
               cnt      <= cnt + 1'b1;
               pc       <= {pc_sum, pc[`BITSER_XLEN-1:1]};
               pc_carry <= pc_cout & ~o_cnt_last;
               if (o_cnt_last) begin
                  if (i_is_store) begin
                     o_dbus_cyc <= 1'b1;
                     phase      <= bitser_ctrl_pkg::STORE_BUS;
                  end else begin
                     o_ibus_cyc <= 1'b1;
                     phase      <= bitser_ctrl_pkg::FETCH;
                  end
               end
            end
            bitser_ctrl_pkg::STORE_BUS: begin
               if (i_dbus_ack) begin
                  o_dbus_cyc <= 1'b0;
                  o_ibus_cyc <= 1'b1;
                  phase      <= bitser_ctrl_pkg::FETCH;
               end
            end
            default: phase <= bitser_ctrl_pkg::FETCH;
         endcase
      end
   end

endmodule
`default_nettype wire

// File: src/bitser_decode.sv
`default_nettype none
`include "bitser_consts.svh"

module bitser_decode (
   input  logic                     clk,
   input  logic                     i_capture,
   input  logic [`BITSER_XLEN-1:0]  i_ibus_rdt,
   output bitser_ctrl_pkg::alu_op_e o_alu_op,
   output logic                     o_use_imm,
   output logic                     o_imm_bit,
   output logic                     o_writes_rd,
   output logic                     o_is_store,
   bitser_rf_if.core                rf
);

   bitser_isa_pkg::insn_u    insn;
   logic [`BITSER_XLEN-1:0]  imm_i;
   logic [`BITSER_XLEN-1:0]  imm_s;
   logic [`BITSER_XLEN-1:0]  imm_u;
   logic [`BITSER_XLEN-1:0]  imm;
   bitser_ctrl_pkg::alu_op_e f3_op;
   logic                     f3_ok;

   always_ff @(posedge clk) begin
      if (i_capture) begin
         insn <= i_ibus_rdt;
      end
   end

   assign rf.rs1_addr = insn.r.rs1;
   assign rf.rs2_addr = insn.s.rs2;
   assign rf.rd_addr  = insn.u.rd;

   assign imm_i = {{(`BITSER_XLEN-12){insn.i.imm[11]}}, insn.i.imm};
   assign imm_s = {{(`BITSER_XLEN-12){insn.s.imm_hi[6]}}, insn.s.imm_hi, insn.s.imm_lo};
   assign imm_u = {insn.u.imm, 12'b0};

   // Shared by register and immediate ops
   always_comb begin
      f3_ok = 1'b1;
      case (insn.r.funct3)
         bitser_isa_pkg::F3_ADD_SUB: f3_op = bitser_ctrl_pkg::ADD;
         bitser_isa_pkg::F3_XOR:     f3_op = bitser_ctrl_pkg::XOR;
         bitser_isa_pkg::F3_OR:      f3_op = bitser_ctrl_pkg::OR;
         bitser_isa_pkg::F3_AND:     f3_op = bitser_ctrl_pkg::AND;
         default: begin
            f3_op = bitser_ctrl_pkg::ADD;
            f3_ok = 1'b0;
         end
      endcase
   end

   always_comb begin
      o_alu_op    = bitser_ctrl_pkg::ADD;
      o_use_imm   = 1'b0;
      o_writes_rd = 1'b0;
      o_is_store  = 1'b0;
      imm         = imm_i;
      case (insn.r.opcode)
         bitser_isa_pkg::OP: begin
            o_writes_rd = f3_ok;
            o_alu_op    = f3_op;
            if (f3_op == bitser_ctrl_pkg::ADD && insn.r.funct7 == bitser_isa_pkg::F7_SUB) begin
               o_alu_op = bitser_ctrl_pkg::SUB;
            end
         end
         bitser_isa_pkg::OP_IMM: begin
            o_use_imm   = 1'b1;
            o_writes_rd = f3_ok;
            o_alu_op    = f3_op;
         end
         bitser_isa_pkg::LUI: begin
            o_alu_op    = bitser_ctrl_pkg::PASS_B;
            o_use_imm   = 1'b1;
            o_writes_rd = 1'b1;
            imm         = imm_u;
         end
         bitser_isa_pkg::STORE: begin
            // Address is rs1 + offset through the adder
            o_use_imm  = 1'b1;
            o_is_store = 1'b1;
            imm        = imm_s;
         end
         default: begin
            o_writes_rd = 1'b0;
            o_is_store  = 1'b0;
         end
      endcase
   end

   assign o_imm_bit = imm[rf.cnt];

endmodule
`default_nettype wire

// File: src/bitser_datapath.sv
`default_nettype none
`include "bitser_consts.svh"

module bitser_datapath (
   input  logic                     clk,
   input  logic                     i_exec_en,
   input  logic                     i_cnt_last,
   input  bitser_ctrl_pkg::alu_op_e i_alu_op,
   input  logic                     i_use_imm,
   input  logic                     i_imm_bit,
   input  logic                     i_writes_rd,
   input  logic                     i_is_store,
   output logic [`BITSER_XLEN-1:0]  o_dbus_adr,
   output logic [`BITSER_XLEN-1:0]  o_dbus_dat,
   bitser_rf_if.core                rf
);

   logic op_a;
   logic op_b;
   logic sub;
   logic a_eff;
   logic sum;
   logic carry;
   logic carry_out;
   logic result;

   assign op_a = rf.rs1_bit;
   assign op_b = i_use_imm ? i_imm_bit : rf.rs2_bit;
   assign sub  = (i_alu_op == bitser_ctrl_pkg::SUB);

   // Carry register holds the borrow when subtracting
   assign a_eff     = op_a ^ sub;
   assign sum       = op_a ^ op_b ^ carry;
   assign carry_out = (a_eff & op_b) | (carry & (a_eff ^ op_b));

   always_comb begin
      case (i_alu_op)
         bitser_ctrl_pkg::ADD,
         bitser_ctrl_pkg::SUB:    result = sum;
         bitser_ctrl_pkg::AND:    result = op_a & op_b;
         bitser_ctrl_pkg::OR:     result = op_a | op_b;
         bitser_ctrl_pkg::XOR:    result = op_a ^ op_b;
         bitser_ctrl_pkg::PASS_B: result = op_b;
         default:                 result = sum;
      endcase
   end

   assign rf.wen   = i_exec_en & i_writes_rd;
   assign rf.wdata = result;

   always_ff @(posedge clk) begin
      // Zero outside execute and after the last bit
      carry <= i_exec_en & ~i_cnt_last & carry_out;
      // Filled LSB first, then held while the bus waits
      if (i_exec_en && i_is_store) begin
         o_dbus_adr <= {sum, o_dbus_adr[`BITSER_XLEN-1:1]};
         o_dbus_dat <= {rf.rs2_bit, o_dbus_dat[`BITSER_XLEN-1:1]};
      end
   end

endmodule
`default_nettype wire

// File: src/bitser_rf.sv
`default_nettype none
`include "bitser_consts.svh"

module bitser_rf (
   input logic     clk,
   bitser_rf_if.rf rf
);

   logic [`BITSER_XLEN-1:0] regs [`BITSER_NREGS];
   logic                    rs1_zero;
   logic                    rs2_zero;

   // x0 is never written and always reads zero
   assign rs1_zero = (rf.rs1_addr == '0);
   assign rs2_zero = (rf.rs2_addr == '0);

   assign rf.rs1_bit = ~rs1_zero & regs[rf.rs1_addr][rf.cnt];
   assign rf.rs2_bit = ~rs2_zero & regs[rf.rs2_addr][rf.cnt];

   always_ff @(posedge clk) begin
      if (rf.wen && rf.rd_addr != '0) begin
         regs[rf.rd_addr][rf.cnt] <= rf.wdata;
      end
   end

endmodule
`default_nettype wire

// File: src/bitser_top.sv
`default_nettype none
`include "bitser_consts.svh"

module bitser_top (
   input  logic                    clk,
   input  logic                    i_reset,
   input  logic [`BITSER_XLEN-1:0] i_ibus_rdt,
   input  logic                    i_ibus_ack,
   input  logic                    i_dbus_ack,
   output logic [`BITSER_XLEN-1:0] o_ibus_adr,
   output logic                    o_ibus_cyc,
   output logic [`BITSER_XLEN-1:0] o_dbus_adr,
   output logic [`BITSER_XLEN-1:0] o_dbus_dat,
   output logic                    o_dbus_cyc
);

   logic                     capture;
   logic                     exec_en;
   logic                     cnt_last;
   logic                     is_store;
   bitser_ctrl_pkg::alu_op_e alu_op;
   logic                     use_imm;
   logic                     imm_bit;
   logic                     writes_rd;

   bitser_rf_if rf_bus ();

   bitser_ctrl ctrl (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .i_is_store (is_store),
      .o_ibus_cyc (o_ibus_cyc),
      .o_ibus_adr (o_ibus_adr),
      .o_dbus_cyc (o_dbus_cyc),
      .o_capture  (capture),
      .o_exec_en  (exec_en),
      .o_cnt_last (cnt_last),
      .rf         (rf_bus.core)
   );

   bitser_decode decode (
      .clk         (clk),
      .i_capture   (capture),
      .i_ibus_rdt  (i_ibus_rdt),
      .o_alu_op    (alu_op),
      .o_use_imm   (use_imm),
      .o_imm_bit   (imm_bit),
      .o_writes_rd (writes_rd),
      .o_is_store  (is_store),
      .rf          (rf_bus.core)
   );

   bitser_datapath datapath (
      .clk         (clk),
      .i_exec_en   (exec_en),
      .i_cnt_last  (cnt_last),
      .i_alu_op    (alu_op),
      .i_use_imm   (use_imm),
      .i_imm_bit   (imm_bit),
      .i_writes_rd (writes_rd),
      .i_is_store  (is_store),
      .o_dbus_adr  (o_dbus_adr),
      .o_dbus_dat  (o_dbus_dat),
      .rf          (rf_bus.core)
   );

   bitser_rf regfile (
      .clk (clk),
      .rf  (rf_bus.rf)
   );

endmodule
`default_nettype wire

// File: verif/bitser_chk.sv
`default_nettype none
`include "bitser_consts.svh"

module bitser_chk (
   input logic                    clk,
   input logic                    i_reset,
   input logic                    i_ibus_cyc,
   input logic                    i_ibus_ack,
   input logic                    i_dbus_cyc,
   input logic                    i_dbus_ack,
   input logic [`BITSER_XLEN-1:0] i_dbus_adr,
   input logic [`BITSER_XLEN-1:0] i_dbus_dat
);

   // Only one bus active at a time
   a_one_bus: assert property (@(posedge clk) disable iff (i_reset)
      !(i_ibus_cyc && i_dbus_cyc))
      else $error("instruction and data bus cyc high together");

   a_dbus_stable: assert property (@(posedge clk) disable iff (i_reset)
      i_dbus_cyc && !i_dbus_ack |=> $stable(i_dbus_adr) && $stable(i_dbus_dat))
      else $error("data bus address or data changed while waiting");

   a_ibus_held: assert property (@(posedge clk) disable iff (i_reset)
      i_ibus_cyc && !i_ibus_ack |=> i_ibus_cyc)
      else $error("instruction bus cyc dropped before ack");

   a_dbus_held: assert property (@(posedge clk) disable iff (i_reset)
      i_dbus_cyc && !i_dbus_ack |=> i_dbus_cyc)
      else $error("data bus cyc dropped before ack");

endmodule

bind bitser_top bitser_chk chk (
   .clk        (clk),
   .i_reset    (i_reset),
   .i_ibus_cyc (o_ibus_cyc),
   .i_ibus_ack (i_ibus_ack),
   .i_dbus_cyc (o_dbus_cyc),
   .i_dbus_ack (i_dbus_ack),
   .i_dbus_adr (o_dbus_adr),
   .i_dbus_dat (o_dbus_dat)
);
`default_nettype wire

// File: verif/bitser_tb.sv
`include "bitser_consts.svh"

module bitser_tb;

   localparam int          MEM_WORDS   = 64;
   localparam int          WAIT_LIMIT  = 200;
   localparam int          MAX_FETCHES = 64;
   localparam logic [31:0] NOP_WORD    = 32'h0000_0013;
   localparam logic [6:0]  STORE_OPC   = 7'b0100011;

   logic                    clk;
   logic                    reset;
   logic [`BITSER_XLEN-1:0] ibus_rdt;
   logic                    ibus_ack;
   logic                    dbus_ack;
   logic [`BITSER_XLEN-1:0] ibus_adr;
   logic                    ibus_cyc;
   logic [`BITSER_XLEN-1:0] dbus_adr;
   logic [`BITSER_XLEN-1:0] dbus_dat;
   logic                    dbus_cyc;

   logic [31:0] input_mem [0:MEM_WORDS-1];
   int          prog_len;
   int          store_count;
   int          stores_done;
   int          fetches;
   int          n_checks;
   int          n_errors;
   int          n_timeouts;
   logic [31:0] expect_pc;
   logic [31:0] last_word;
   logic        ok;

   bitser_top i_dut (
      .clk        (clk),
      .i_reset    (reset),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .i_dbus_ack (dbus_ack),
      .o_ibus_adr (ibus_adr),
      .o_ibus_cyc (ibus_cyc),
      .o_dbus_adr (dbus_adr),
      .o_dbus_dat (dbus_dat),
      .o_dbus_cyc (dbus_cyc)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
      n_checks++;
      if (got !== expected) begin
         n_errors++;
         $display("error at time %0t: %s is %h, expected %h", $time, what, got, expected);
      end
   endtask

   task automatic hold_cycles(input int n);
      int i;
      for (i = 0; i < n; i++) begin
         @(posedge clk);
         #1;
      end
   endtask

   // Wait for cyc on one bus, bounded
   task automatic wait_for_cyc(input logic on_dbus, output logic seen);
      int n;
      n = 0;
      while (!(on_dbus ? dbus_cyc : ibus_cyc) && n < WAIT_LIMIT) begin
         @(posedge clk);
         #1;
         n++;
      end
      seen = on_dbus ? dbus_cyc : ibus_cyc;
      if (!seen) begin
         n_timeouts++;
         if (on_dbus) begin
            $display("timeout at %0t: data bus never requested the store", $time);
         end else begin
            $display("timeout at %0t: instruction bus never requested a fetch", $time);
         end
      end
   endtask

   task automatic serve_fetch();
      logic [31:0] idx;
      check_value("fetch address", ibus_adr, expect_pc);
      idx = ibus_adr >> 2;
      hold_cycles($urandom % 4);
      // Past the program end the core sees NOPs
      if (idx < prog_len) begin
         last_word = input_mem[1 + idx];
      end else begin
         last_word = NOP_WORD;
      end
      ibus_rdt = last_word;
      ibus_ack = 1'b1;
      @(posedge clk);
      #1;
      ibus_ack  = 1'b0;
      expect_pc = expect_pc + 4;
      fetches++;
   endtask

   task automatic serve_store();
      int base;
      hold_cycles($urandom % 5);
      dbus_ack = 1'b1;
      base     = prog_len + 2 + 2 * stores_done;
      check_value("store address", dbus_adr, input_mem[base]);
      check_value("store data", dbus_dat, input_mem[base + 1]);
      @(posedge clk);
      #1;
      dbus_ack = 1'b0;
      stores_done++;
   endtask

   initial begin
      reset       = 1'b1;
      ibus_rdt    = '0;
      ibus_ack    = 1'b0;
      dbus_ack    = 1'b0;
      n_checks    = 0;
      n_errors    = 0;
      n_timeouts  = 0;
      stores_done = 0;
      fetches     = 0;
      last_word   = NOP_WORD;
      expect_pc   = `BITSER_RESET_PC;
      ok          = 1'b1;
      void'($urandom(32'h2d6f8ba9));
      $readmemh("verif/bitser_input.mem", input_mem);
      prog_len    = input_mem[0];
      store_count = input_mem[prog_len + 1];
      if ($isunknown(input_mem[0]) || store_count <= 0) begin
         n_errors++;
         ok = 1'b0;
         $display("could not read program and stores from verif/bitser_input.mem");
      end

      repeat (8) begin
         @(posedge clk);
         #1;
         check_value("ibus cyc in reset", 32'(ibus_cyc), 32'h0);
         check_value("dbus cyc in reset", 32'(dbus_cyc), 32'h0);
      end
      reset = 1'b0;

      while (ok && stores_done < store_count) begin
         if (fetches >= MAX_FETCHES) begin
            n_timeouts++;
            ok = 1'b0;
            $display("%0d fetches done and stores still missing", fetches);
         end else begin
            wait_for_cyc(1'b0, ok);
            if (ok) begin
               serve_fetch();
               if (last_word[6:0] == STORE_OPC) begin
                  wait_for_cyc(1'b1, ok);
                  if (ok) begin
                     serve_store();
                  end
               end
            end
         end
      end

      $display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
      if (n_errors == 0 && n_timeouts == 0 && stores_done == store_count) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: bitser.f
+incdir+include
src/bitser_isa_pkg.sv
src/bitser_ctrl_pkg.sv
src/bitser_rf_if.sv
src/bitser_ctrl.sv
src/bitser_decode.sv
src/bitser_datapath.sv
src/bitser_rf.sv
src/bitser_top.sv
verif/bitser_chk.sv
verif/bitser_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= bitser_tb
FILELIST  ?= bitser.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST)) include/bitser_consts.svh
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(OBJ_DIR)/V%: $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $* --Mdir $(OBJ_DIR) -o V$*

run: $(SIM) verif/bitser_input.mem
	./$(SIM) > $(LOG) 2>&1; cat $(LOG); grep -q "^TEST PASSED$$" $(LOG)

check: run
	@echo "pass message found in $(LOG)"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/bitser_input.mem
// Word 0 program length, then program words, then store count
// Then one expected store per line as address and data
00000013
123450b7 // lui   x1, 0x12345
fff08113 // addi  x2, x1, -1
ff000193 // addi  x3, x0, -16
00310233 // add   x4, x2, x3
401182b3 // sub   x5, x3, x1
00517333 // and   x6, x2, x5
0060e3b3 // or    x7, x1, x6
00524433 // xor   x8, x4, x5
f002f493 // andi  x9, x5, -256
8a50e513 // ori   x10, x1, 0x8a5
fff0c593 // xori  x11, x1, -1
00108033 // add   x0, x1, x1
0000000f // fence, retires as no-op
0040a423 // sw    x4, 8(x1)
fe512e23 // sw    x5, -4(x2)
0061a023 // sw    x6, 0(x3)
0083a823 // sw    x8, 16(x7)
80a4a023 // sw    x10, -2048(x9)
0005a223 // sw    x0, 4(x11)
00000006
12345008 12344fef
12344ffb edcbaff0
fffffff0 00000ff0
12346000 ffffe01f
edcba700 fffff8a5
edcbb003 00000000
